/* hdl/rv_decode_macros.svh */
`ifndef RV_DECODE_MACROS_SVH
`define RV_DECODE_MACROS_SVH

`define RV_XLEN         32
`define RV_IADDR_BITS   16

// major opcodes, instruction bits 6..2
`define RV_OPC_LOAD     5'b00000
`define RV_OPC_OP_IMM   5'b00100
`define RV_OPC_AUIPC    5'b00101
`define RV_OPC_STORE    5'b01000
`define RV_OPC_OP       5'b01100
`define RV_OPC_LUI      5'b01101
`define RV_OPC_BRANCH   5'b11000
`define RV_OPC_JALR     5'b11001
`define RV_OPC_JAL      5'b11011
`define RV_OPC_SYSTEM   5'b11100
`define RV_OPC_DET      2'b11

`define RV_F3_JALR      3'b000
`define RV_F3_PRIV      3'b000
// low two funct3 bits of the csr group, upper two of slt/sltu
`define RV_F3L_CSRRW    2'b01
`define RV_F3L_CSRRS    2'b10
`define RV_F3L_CSRRC    2'b11
`define RV_F3H_SLT      2'b01

`endif

/* hdl/rv_decode_pkg.sv */
package rv_decode_pkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [4:0] op;
        logic [1:0] op_det;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    // branch offset is scattered, bit 0 implied zero
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    typedef struct packed {
        logic add_override;
        logic op2_inverse;
        logic sh_ar;
    } alu_ctrl_t;

    typedef struct packed {
        logic memory;
        logic pc_next;
        logic alu;
    } res_src_t;

endpackage

/* hdl/rv_instr_if.sv */
`include "rv_decode_macros.svh"

interface rv_instr_if;

    rv_decode_pkg::instr_u          instr;
    logic [`RV_IADDR_BITS-1:1]      pc;
    logic [`RV_IADDR_BITS-1:1]      pc_next;
    logic                           valid;

    modport producer
    (
        output instr, pc, pc_next, valid
    );

    modport consumer
    (
        input  instr, pc, pc_next, valid
    );

endinterface

/* hdl/rv_instr_buffer.sv */
`include "rv_decode_macros.svh"

module rv_instr_buffer
(
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_stall,
    input  logic                        i_flush,
    input  logic                        i_ready,
    input  logic [`RV_XLEN-1:0]         i_instruction,
    input  logic [`RV_IADDR_BITS-1:1]   i_pc,
    input  logic [`RV_IADDR_BITS-1:1]   i_pc_next,
    rv_instr_if.producer                o_instr
);

    logic [`RV_XLEN-1:0] instr_gated;

    // zero word when not ready, it carries no full-length marker
    assign instr_gated = i_ready ? i_instruction : '0;

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_instr.instr   <= '0;
            o_instr.valid   <= 1'b0;
            o_instr.pc      <= '0;
            o_instr.pc_next <= '0;
        end
        else if (i_flush)
        begin
            // pcs keep their old value
            o_instr.instr   <= '0;
            o_instr.valid   <= 1'b0;
        end
        else if (!i_stall)
        begin
            o_instr.instr   <= instr_gated;
            o_instr.valid   <= i_ready;
            o_instr.pc      <= i_pc;
            o_instr.pc_next <= i_pc_next;
        end
    end

    a_flush_clears_valid: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_flush |=> !o_instr.valid
    );

    a_stall_holds: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (i_stall && !i_flush) |=> ($stable(o_instr.instr) && $stable(o_instr.pc))
    );

endmodule

/* hdl/rv_imm_gen.sv */
`include "rv_decode_macros.svh"

module rv_imm_gen
(
    rv_instr_if.consumer            i_instr,
    output logic [`RV_XLEN-1:0]     o_imm
);

    logic [4:0]             op;
    logic                   is_u;
    logic                   is_j;
    logic                   is_s;
    logic                   is_b;
    logic [`RV_XLEN-1:0]    imm_i;
    logic [`RV_XLEN-1:0]    imm_s;
    logic [`RV_XLEN-1:0]    imm_b;
    logic [`RV_XLEN-1:0]    imm_u;
    logic [`RV_XLEN-1:0]    imm_j;

    assign op = i_instr.instr.r.op;

    assign imm_i = {{(`RV_XLEN-12){i_instr.instr.i.imm_11_0[11]}}, i_instr.instr.i.imm_11_0};
    assign imm_s = {{(`RV_XLEN-12){i_instr.instr.s.imm_11_5[6]}},
                    i_instr.instr.s.imm_11_5, i_instr.instr.s.imm_4_0};
    assign imm_b = {{(`RV_XLEN-13){i_instr.instr.b.imm_12}}, i_instr.instr.b.imm_12,
                    i_instr.instr.b.imm_11, i_instr.instr.b.imm_10_5,
                    i_instr.instr.b.imm_4_1, 1'b0};
    assign imm_u = {i_instr.instr.u.imm_31_12, {(`RV_XLEN-20){1'b0}}};
    assign imm_j = {{(`RV_XLEN-21){i_instr.instr.j.imm_20}}, i_instr.instr.j.imm_20,
                    i_instr.instr.j.imm_19_12, i_instr.instr.j.imm_11,
                    i_instr.instr.j.imm_10_1, 1'b0};

    assign is_u = (op == `RV_OPC_LUI) || (op == `RV_OPC_AUIPC);
    assign is_j = (op == `RV_OPC_JAL);
    assign is_s = (op == `RV_OPC_STORE);
    assign is_b = (op == `RV_OPC_BRANCH);

    // loads, op-imm, jalr and system all use the I form
    assign o_imm = is_u ? imm_u :
                   is_j ? imm_j :
                   is_s ? imm_s :
                   is_b ? imm_b :
                          imm_i;

    a_imm_even: assert final (i_instr.valid !== 1'b1 || !(is_b || is_j) || !o_imm[0]);

endmodule

/* hdl/rv_ctrl_decode.sv */
`include "rv_decode_macros.svh"

module rv_ctrl_decode
(
    rv_instr_if.consumer                i_instr,
    output logic [4:0]                  o_rs1,
    output logic [4:0]                  o_rs2,
    output logic [4:0]                  o_rd,
    output logic [2:0]                  o_funct3,
    output rv_decode_pkg::alu_ctrl_t    o_alu_ctrl,
    output rv_decode_pkg::res_src_t     o_res_src,
    output logic                        o_reg_write,
    output logic                        o_op1_src,
    output logic                        o_op2_src,
    output logic [11:0]                 o_csr_idx,
    output logic [4:0]                  o_csr_imm,
    output logic                        o_csr_write,
    output logic                        o_csr_set,
    output logic                        o_csr_clear,
    output logic                        o_csr_read,
    output logic                        o_csr_ebreak,
    output logic                        o_inst_mret,
    output logic                        o_inst_jalr,
    output logic                        o_inst_jal,
    output logic                        o_inst_branch,
    output logic                        o_inst_store,
    output logic                        o_inst_supported
);

    logic [4:0] op;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic       inst_full;
    logic       grp_load, grp_ari, grp_store, grp_reg, grp_arr, grp_branch, grp_sys;
    logic       inst_auipc, inst_lui, op_jalr, inst_jalr, inst_jal;
    logic       grp_trap, inst_ecall, inst_ebreak, inst_mret, inst_csr;
    logic       alu_add, alu_inv, inv_off, op2_reg, res_mem, res_pc_next;

    assign op        = i_instr.instr.r.op;
    assign funct3    = i_instr.instr.r.funct3;
    assign funct7    = i_instr.instr.r.funct7;
    assign rs2       = i_instr.instr.r.rs2;
    assign inst_full = (i_instr.instr.r.op_det == `RV_OPC_DET);

    assign grp_load   = inst_full && (op == `RV_OPC_LOAD);
    assign grp_ari    = inst_full && (op == `RV_OPC_OP_IMM);
    assign grp_store  = inst_full && (op == `RV_OPC_STORE);
    assign grp_reg    = inst_full && (op == `RV_OPC_OP);
    assign grp_branch = inst_full && (op == `RV_OPC_BRANCH);
    assign grp_sys    = inst_full && (op == `RV_OPC_SYSTEM);
    assign inst_auipc = inst_full && (op == `RV_OPC_AUIPC);
    assign inst_lui   = inst_full && (op == `RV_OPC_LUI);
    assign inst_jal   = inst_full && (op == `RV_OPC_JAL);
    assign op_jalr    = inst_full && (op == `RV_OPC_JALR);
    assign inst_jalr  = op_jalr && (funct3 == `RV_F3_JALR);
    // funct7 bit 0 set means mul/div
    assign grp_arr    = grp_reg && !funct7[0];

    // ecall, ebreak and mret share funct3 zero
    assign grp_trap    = grp_sys && (funct3 == `RV_F3_PRIV);
    assign inst_csr    = grp_sys && (funct3 != `RV_F3_PRIV);
    assign inst_ecall  = grp_trap && !funct7[3] && !rs2[0];
    assign inst_ebreak = grp_trap && !funct7[3] && rs2[0];
    assign inst_mret   = grp_trap && funct7[4] && (rs2[2:1] == 2'b01);

    // address calculation and upper-immediate paths force an add
    assign alu_add = grp_load || grp_store || inst_auipc || inst_lui || inst_jal;
    assign alu_inv = grp_branch ||
                     (grp_ari && (funct3[2:1] == `RV_F3H_SLT)) ||
                     (grp_arr && (funct3[2:1] == `RV_F3H_SLT));
    assign inv_off = alu_add || grp_ari;

    assign o_alu_ctrl.add_override = alu_add;
    assign o_alu_ctrl.op2_inverse  = alu_inv ? 1'b1 :
                                     inv_off ? 1'b0 :
                                               inst_full && funct7[5];
    assign o_alu_ctrl.sh_ar        = inst_full && funct7[5];

    assign res_mem     = grp_load;
    assign res_pc_next = op_jalr || inst_jal;
    assign op2_reg     = (op == `RV_OPC_OP) || (op == `RV_OPC_BRANCH);

    assign o_res_src.memory  = res_mem;
    assign o_res_src.pc_next = res_pc_next;
    assign o_res_src.alu     = inst_full && !(res_mem || res_pc_next);

    assign o_reg_write = inst_full && !(op == `RV_OPC_STORE) && !(op == `RV_OPC_BRANCH);
    assign o_op1_src   = inst_auipc || inst_jal;
    assign o_op2_src   = inst_full && !op2_reg;

    assign o_rd     = i_instr.instr.r.rd;
    assign o_rs1    = inst_lui ? 5'd0 : i_instr.instr.r.rs1;
    assign o_rs2    = rs2;
    assign o_funct3 = funct3;

    assign o_csr_idx    = {funct7, rs2};
    assign o_csr_imm    = i_instr.instr.r.rs1;
    assign o_csr_write  = grp_sys && (funct3[1:0] == `RV_F3L_CSRRW);
    assign o_csr_set    = grp_sys && (funct3[1:0] == `RV_F3L_CSRRS);
    assign o_csr_clear  = grp_sys && (funct3[1:0] == `RV_F3L_CSRRC);
    assign o_csr_read   = inst_csr;
    assign o_csr_ebreak = inst_ebreak;

    assign o_inst_mret   = inst_mret;
    assign o_inst_jalr   = op_jalr;
    assign o_inst_jal    = inst_jal;
    assign o_inst_branch = grp_branch;
    assign o_inst_store  = grp_store;

    // an empty slot never raises an illegal-instruction trap
    assign o_inst_supported = !i_instr.valid ||
                              grp_load || grp_ari || inst_auipc || grp_store ||
                              grp_arr || inst_lui || grp_branch || inst_jalr ||
                              inst_jal || inst_ecall || inst_ebreak || inst_mret ||
                              inst_csr;

    a_res_onehot: assert final (inst_full !== 1'b1 || $onehot(o_res_src));

endmodule

/* hdl/rv_decode.sv */
`include "rv_decode_macros.svh"

module rv_decode
(
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_stall,
    input  logic                        i_flush,
    input  logic                        i_ready,
    input  logic [`RV_XLEN-1:0]         i_instruction,
    input  logic [`RV_IADDR_BITS-1:1]   i_pc,
    input  logic [`RV_IADDR_BITS-1:1]   i_pc_next,
    output logic [`RV_IADDR_BITS-1:1]   o_pc,
    output logic [`RV_IADDR_BITS-1:1]   o_pc_next,
    output logic [4:0]                  o_rs1,
    output logic [4:0]                  o_rs2,
    output logic [4:0]                  o_rd,
    output logic [`RV_XLEN-1:0]         o_imm,
    output logic [2:0]                  o_funct3,
    output logic                        o_alu_add,
    output logic                        o_alu_op2_inv,
    output logic                        o_alu_sh_ar,
    output logic                        o_res_mem,
    output logic                        o_res_pc_next,
    output logic                        o_res_alu,
    output logic                        o_reg_write,
    output logic                        o_op1_src,
    output logic                        o_op2_src,
    output logic [11:0]                 o_csr_idx,
    output logic [4:0]                  o_csr_imm,
    output logic                        o_csr_write,
    output logic                        o_csr_set,
    output logic                        o_csr_clear,
    output logic                        o_csr_read,
    output logic                        o_csr_ebreak,
    output logic                        o_inst_mret,
    output logic                        o_inst_jalr,
    output logic                        o_inst_jal,
    output logic                        o_inst_branch,
    output logic                        o_inst_store,
    output logic                        o_inst_supported
);

    rv_decode_pkg::alu_ctrl_t   alu_ctrl;
    rv_decode_pkg::res_src_t    res_src;

    rv_instr_if u_instr_if ();

    rv_instr_buffer u_buffer
    (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_stall        (i_stall),
        .i_flush        (i_flush),
        .i_ready        (i_ready),
        .i_instruction  (i_instruction),
        .i_pc           (i_pc),
        .i_pc_next      (i_pc_next),
        .o_instr        (u_instr_if.producer)
    );

    rv_imm_gen u_imm_gen
    (
        .i_instr        (u_instr_if.consumer),
        .o_imm          (o_imm)
    );

    rv_ctrl_decode u_ctrl
    (
        .i_instr            (u_instr_if.consumer),
        .o_rs1              (o_rs1),
        .o_rs2              (o_rs2),
        .o_rd               (o_rd),
        .o_funct3           (o_funct3),
        .o_alu_ctrl         (alu_ctrl),
        .o_res_src          (res_src),
        .o_reg_write        (o_reg_write),
        .o_op1_src          (o_op1_src),
        .o_op2_src          (o_op2_src),
        .o_csr_idx          (o_csr_idx),
        .o_csr_imm          (o_csr_imm),
        .o_csr_write        (o_csr_write),
        .o_csr_set          (o_csr_set),
        .o_csr_clear        (o_csr_clear),
        .o_csr_read         (o_csr_read),
        .o_csr_ebreak       (o_csr_ebreak),
        .o_inst_mret        (o_inst_mret),
        .o_inst_jalr        (o_inst_jalr),
        .o_inst_jal         (o_inst_jal),
        .o_inst_branch      (o_inst_branch),
        .o_inst_store       (o_inst_store),
        .o_inst_supported   (o_inst_supported)
    );

    assign o_pc          = u_instr_if.pc;
    assign o_pc_next     = u_instr_if.pc_next;
    assign o_alu_add     = alu_ctrl.add_override;
    assign o_alu_op2_inv = alu_ctrl.op2_inverse;
    assign o_alu_sh_ar   = alu_ctrl.sh_ar;
    assign o_res_mem     = res_src.memory;
    assign o_res_pc_next = res_src.pc_next;
    assign o_res_alu     = res_src.alu;

endmodule

/* tests/tb_rv_decode.sv */
`include "rv_decode_macros.svh"

module tb_rv_decode;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MEM_WORDS     = 512;
    localparam int VEC_WORDS     = 10;
    localparam int RESET_CYCLES  = 16;
    localparam int RESET_TIMEOUT = 64;

    logic                       i_clk;
    logic                       i_rst_n;
    logic                       i_stall;
    logic                       i_flush;
    logic                       i_ready;
    logic [`RV_XLEN-1:0]        i_instruction;
    logic [`RV_IADDR_BITS-1:1]  i_pc;
    logic [`RV_IADDR_BITS-1:1]  i_pc_next;
    logic [`RV_IADDR_BITS-1:1]  o_pc;
    logic [`RV_IADDR_BITS-1:1]  o_pc_next;
    logic [4:0]                 o_rs1;
    logic [4:0]                 o_rs2;
    logic [4:0]                 o_rd;
    logic [`RV_XLEN-1:0]        o_imm;
    logic [2:0]                 o_funct3;
    logic                       o_alu_add;
    logic                       o_alu_op2_inv;
    logic                       o_alu_sh_ar;
    logic                       o_res_mem;
    logic                       o_res_pc_next;
    logic                       o_res_alu;
    logic                       o_reg_write;
    logic                       o_op1_src;
    logic                       o_op2_src;
    logic [11:0]                o_csr_idx;
    logic [4:0]                 o_csr_imm;
    logic                       o_csr_write;
    logic                       o_csr_set;
    logic                       o_csr_clear;
    logic                       o_csr_read;
    logic                       o_csr_ebreak;
    logic                       o_inst_mret;
    logic                       o_inst_jalr;
    logic                       o_inst_jal;
    logic                       o_inst_branch;
    logic                       o_inst_store;
    logic                       o_inst_supported;

    logic [31:0]                pat_mem [0:MEM_WORDS-1];
    logic [18:0]                got_ctrl;
    int                         errors;
    int                         checks;
    int                         num_vecs;

    // expected contents of the instruction register
    logic [31:0]                ref_instr;
    logic [`RV_IADDR_BITS-1:1]  ref_pc;
    logic [`RV_IADDR_BITS-1:1]  ref_pc_next;

    rv_decode DUT
    (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_stall(i_stall), .i_flush(i_flush),
        .i_ready(i_ready), .i_instruction(i_instruction), .i_pc(i_pc), .i_pc_next(i_pc_next),
        .o_pc(o_pc), .o_pc_next(o_pc_next), .o_rs1(o_rs1), .o_rs2(o_rs2), .o_rd(o_rd),
        .o_imm(o_imm), .o_funct3(o_funct3), .o_alu_add(o_alu_add),
        .o_alu_op2_inv(o_alu_op2_inv), .o_alu_sh_ar(o_alu_sh_ar), .o_res_mem(o_res_mem),
        .o_res_pc_next(o_res_pc_next), .o_res_alu(o_res_alu), .o_reg_write(o_reg_write),
        .o_op1_src(o_op1_src), .o_op2_src(o_op2_src), .o_csr_idx(o_csr_idx),
        .o_csr_imm(o_csr_imm), .o_csr_write(o_csr_write), .o_csr_set(o_csr_set),
        .o_csr_clear(o_csr_clear), .o_csr_read(o_csr_read), .o_csr_ebreak(o_csr_ebreak),
        .o_inst_mret(o_inst_mret), .o_inst_jalr(o_inst_jalr), .o_inst_jal(o_inst_jal),
        .o_inst_branch(o_inst_branch), .o_inst_store(o_inst_store),
        .o_inst_supported(o_inst_supported)
    );

    // same bit order as the control column of the pattern file
    assign got_ctrl = {o_alu_add, o_alu_op2_inv, o_alu_sh_ar, o_res_mem, o_res_pc_next,
                       o_res_alu, o_reg_write, o_op1_src, o_op2_src, o_csr_write, o_csr_set,
                       o_csr_clear, o_csr_read, o_csr_ebreak, o_inst_mret, o_inst_jalr,
                       o_inst_jal, o_inst_branch, o_inst_store};

    initial
    begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    function automatic string ctrl_name(input int b);
        case (b)
            18: return "o_alu_add";
            17: return "o_alu_op2_inv";
            16: return "o_alu_sh_ar";
            15: return "o_res_mem";
            14: return "o_res_pc_next";
            13: return "o_res_alu";
            12: return "o_reg_write";
            11: return "o_op1_src";
            10: return "o_op2_src";
            9:  return "o_csr_write";
            8:  return "o_csr_set";
            7:  return "o_csr_clear";
            6:  return "o_csr_read";
            5:  return "o_csr_ebreak";
            4:  return "o_inst_mret";
            3:  return "o_inst_jalr";
            2:  return "o_inst_jal";
            1:  return "o_inst_branch";
            default: return "o_inst_store";
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAIL at %0d ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic check_outputs(input logic [4:0] rd, input logic [4:0] rs1,
                                 input logic [4:0] rs2, input logic [31:0] imm,
                                 input logic [18:0] ctrl, input logic sup);
        int b;
        check_value("o_rd", o_rd, rd);
        check_value("o_rs1", o_rs1, rs1);
        check_value("o_rs2", o_rs2, rs2);
        check_value("o_imm", o_imm, imm);
        for (b = 0; b < 19; b++)
            check_value(ctrl_name(b), got_ctrl[b], ctrl[b]);
        check_value("o_inst_supported", o_inst_supported, sup);
        // raw fields of the held word
        check_value("o_funct3", o_funct3, ref_instr[14:12]);
        check_value("o_csr_idx", o_csr_idx, ref_instr[31:20]);
        check_value("o_csr_imm", o_csr_imm, ref_instr[19:15]);
        check_value("o_pc", o_pc, ref_pc);
        check_value("o_pc_next", o_pc_next, ref_pc_next);
    endtask

    // ctl is {ready, stall, flush}
    // flush wins and keeps the pcs
    task automatic update_reference(input logic [31:0] word, input logic [31:0] pc,
                                    input logic [31:0] pc_next, input logic [2:0] ctl);
        if (ctl[0])
            ref_instr = '0;
        else if (!ctl[1])
        begin
            ref_instr   = ctl[2] ? word : '0;
            ref_pc      = pc[`RV_IADDR_BITS-1:1];
            ref_pc_next = pc_next[`RV_IADDR_BITS-1:1];
        end
    endtask

    task automatic drive_vector(input int v);
        int base;
        base = 1 + v * VEC_WORDS;
        i_instruction <= pat_mem[base];
        i_pc          <= pat_mem[base + 1][`RV_IADDR_BITS-1:1];
        i_pc_next     <= pat_mem[base + 2][`RV_IADDR_BITS-1:1];
        i_ready       <= pat_mem[base + 3][2];
        i_stall       <= pat_mem[base + 3][1];
        i_flush       <= pat_mem[base + 3][0];
    endtask

    task automatic check_vector(input int v);
        int base;
        base = 1 + v * VEC_WORDS;
        update_reference(pat_mem[base], pat_mem[base + 1], pat_mem[base + 2],
                         pat_mem[base + 3][2:0]);
        check_outputs(pat_mem[base + 4][4:0], pat_mem[base + 5][4:0], pat_mem[base + 6][4:0],
                      pat_mem[base + 7], pat_mem[base + 8][18:0], pat_mem[base + 9][0]);
    endtask

    initial
    begin
        int v;
        int wait_cycles;
        errors        = 0;
        checks        = 0;
        ref_instr     = '0;
        ref_pc        = '0;
        ref_pc_next   = '0;
        i_rst_n       = 1'b0;
        i_stall       = 1'b0;
        i_flush       = 1'b0;
        i_ready       = 1'b0;
        i_instruction = '0;
        i_pc          = '0;
        i_pc_next     = '0;
        $readmemh("tests/rv_decode_patterns.txt", pat_mem);
        num_vecs = pat_mem[0];

        repeat (RESET_CYCLES) @(posedge i_clk);
        i_rst_n <= 1'b1;
        wait_cycles = 0;
        while (i_rst_n !== 1'b1 && wait_cycles < RESET_TIMEOUT)
        begin
            @(posedge i_clk);
            wait_cycles++;
        end

        if (i_rst_n !== 1'b1)
        begin
            errors++;
            $display("reset was not released within %0d cycles", RESET_TIMEOUT);
        end
        else if (num_vecs < 1 || 1 + num_vecs * VEC_WORDS > MEM_WORDS)
        begin
            errors++;
            $display("pattern file has no usable vector count");
        end
        else
        begin
            // empty register right after reset
            @(negedge i_clk);
            check_outputs(5'd0, 5'd0, 5'd0, 32'd0, 19'd0, 1'b1);
            @(posedge i_clk);
            drive_vector(0);
            for (v = 0; v < num_vecs; v++)
            begin
                @(posedge i_clk);
                if (v + 1 < num_vecs)
                    drive_vector(v + 1);
                @(negedge i_clk);
                check_vector(v);
            end
        end

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

/* tests/rv_decode_patterns.txt */
// first word is the vector count, then per line:
// instr pc pc_next ctl{ready,stall,flush} rd rs1 rs2 imm ctrl supported
// ctrl bits 18..0: alu_add op2_inv sh_ar mem pc_next alu reg_write op1 op2
//   csr_write csr_set csr_clear csr_read ebreak mret jalr jal branch store
00000017
ffb10093 0100 0104 4 01 02 1b fffffffb 13400 1 // addi x1, x2, -5
0081a283 0104 0108 4 05 03 08 00000008 49400 1 // lw x5, 8(x3)
00622623 0108 010c 4 0c 04 06 0000000c 42401 1 // sw x6, 12(x4)
fe208ce3 010c 0110 4 19 01 02 fffffff8 32002 1 // beq x1, x2, -8
123453b7 0110 0114 4 07 00 03 12345000 43400 1 // lui x7, 0x12345
fffff417 0114 0118 4 08 1f 1f fffff000 53c00 1 // auipc x8, 0xfffff
010000ef 0118 011c 4 01 00 10 00000010 45c04 1 // jal x1, 16
00008067 011c 0120 4 00 01 00 00000000 05408 1 // jalr x0, 0(x1)
405201b3 0120 0124 4 03 04 05 00000405 33000 1 // sub x3, x4, x5
0083a333 0124 0128 4 06 07 08 00000008 23000 1 // slt x6, x7, x8
40b554b3 0128 012c 4 09 0a 0b 0000040b 33000 1 // sra x9, x10, x11
300110f3 012c 0130 4 01 02 00 00000300 03640 1 // csrrw x1, mstatus, x2
341021f3 0130 0134 4 03 00 01 00000341 03540 1 // csrrs x3, mepc, x0
3042f273 0134 0138 4 04 05 04 00000304 034c0 1 // csrrci x4, mie, 5
00000073 0138 013c 4 00 00 00 00000000 03400 1 // ecall
00100073 013c 0140 4 00 00 01 00000001 03420 1 // ebreak
30200073 0140 0144 4 00 00 02 00000302 03410 1 // mret
ffb10093 0144 0148 6 00 00 02 00000302 03410 1 // stalled, mret stays
0081a283 0148 014c 7 00 00 00 00000000 00000 1 // flush with stall
023100b3 014c 0150 4 01 02 03 00000023 03000 0 // mul x1, x2, x3
003100d3 0150 0154 4 01 02 03 00000003 03400 0 // fadd.s f1, f2, f3
0081a283 0154 0158 0 00 00 00 00000000 00000 1 // ready low, zero word
ffb10093 0158 015c 4 01 02 1b fffffffb 13400 1 // addi x1, x2, -5

/* all.f */
+incdir+hdl
hdl/rv_decode_pkg.sv
hdl/rv_instr_if.sv
hdl/rv_instr_buffer.sv
hdl/rv_imm_gen.sv
hdl/rv_ctrl_decode.sv
hdl/rv_decode.sv
tests/tb_rv_decode.sv

/* Bender.yml */
package:
  name: rv_decode

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rv_decode_pkg.sv
      - hdl/rv_instr_if.sv
      - hdl/rv_instr_buffer.sv
      - hdl/rv_imm_gen.sv
      - hdl/rv_ctrl_decode.sv
      - hdl/rv_decode.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/tb_rv_decode.sv
